/* src/npmPrimitivePkg.sv */
package npmPrimitivePkg;

    // opcodes live in the top nibble of the command word.
    localparam logic [3:0] opcodePhyReset  = 4'd1;
    localparam logic [3:0] opcodeTimedHold = 4'd2;

    // apb byte offsets.
    localparam logic [3:0] addrCommand    = 4'h0;
    localparam logic [3:0] addrStatus     = 4'h4;
    localparam logic [3:0] addrResetCount = 4'h8;
    localparam logic [3:0] addrDoneCount  = 4'hC;

    // default length of one phy reset pulse in clock cycles.
    localparam int defaultResetPulseCycles = 10;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [23:0] reserved;
        logic [3:0]  repeatCount;
    } resetViewT;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] reserved;
        logic [15:0] delayCycles;
    } timerViewT;

    // one command word, read through the view its opcode selects.
    typedef union packed {
        resetViewT resetView;
        timerViewT timerView;
    } primitiveCommandT;

endpackage

/* src/npmApbRegisters.sv */
`timescale 1ns/100ps

module npmApbRegisters
    import npmPrimitivePkg::*;
(
    input  logic             iSystemClock,
    input  logic             iReset,
    input  logic             pSel,
    input  logic             pEnable,
    input  logic             pWrite,
    input  logic [3:0]       pAddr,
    input  logic [31:0]      pWData,
    output logic [31:0]      pRData,
    output logic             pReady,
    output logic             pSlvErr,
    input  logic             busy,
    input  logic             primitiveDone,
    input  logic             resetEdge,
    output logic             commandValid,
    output primitiveCommandT commandWord
);

    primitiveCommandT writeWord;
    primitiveCommandT commandReg;
    logic             access;
    logic             addrKnown;
    logic             commandWrite;
    logic             opcodeError;
    logic             accept;
    logic             statusClear;
    logic             doneFlag;
    logic [31:0]      resetCount;
    logic [31:0]      doneCount;

    assign writeWord    = pWData;
    assign access       = pSel & pEnable;
    assign addrKnown    = pAddr inside {addrCommand, addrStatus, addrResetCount, addrDoneCount};
    assign commandWrite = access & pWrite & (pAddr == addrCommand);

    // the opcode picks which view of the word gets checked.
    always_comb begin
        case (writeWord.resetView.opcode)
            opcodePhyReset:  opcodeError = (writeWord.resetView.repeatCount == 4'd0);
            opcodeTimedHold: opcodeError = (writeWord.timerView.delayCycles == 16'd0);
            default:         opcodeError = 1'b1;
        endcase
    end

    assign accept      = commandWrite & ~busy & ~opcodeError;
    assign statusClear = access & pWrite & (pAddr == addrStatus) & pWData[1];

    assign pReady  = 1'b1;
    assign pSlvErr = access & (~addrKnown | (commandWrite & (busy | opcodeError)));

    always_comb begin
        case (pAddr)
            addrCommand:    pRData = commandReg;
            addrStatus:     pRData = {30'd0, doneFlag, busy};
            addrResetCount: pRData = resetCount;
            addrDoneCount:  pRData = doneCount;
            default:        pRData = 32'd0;
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            commandValid <= 1'b0;
            commandReg   <= '0;
            doneFlag     <= 1'b0;
            resetCount   <= 32'd0;
            doneCount    <= 32'd0;
        end else begin
            commandValid <= accept;
            if (accept) begin
                commandReg <= writeWord;
            end
            // a completion in the same cycle wins over the clear.
            if (primitiveDone) begin
                doneFlag <= 1'b1;
            end else if (statusClear) begin
                doneFlag <= 1'b0;
            end
            if (resetEdge) begin
                resetCount <= resetCount + 32'd1;
            end
            if (primitiveDone) begin
                doneCount <= doneCount + 32'd1;
            end
        end
    end

    assign commandWord = commandReg;

endmodule

/* src/npmPrimitiveDispatcher.sv */
`timescale 1ns/100ps

module npmPrimitiveDispatcher
    import npmPrimitivePkg::*;
(
    input  logic             iSystemClock,
    input  logic             iReset,
    input  logic             commandValid,
    input  primitiveCommandT commandWord,
    input  logic             resetReady,
    input  logic             resetLastStep,
    input  logic             timerBusy,
    input  logic             timerLastStep,
    output logic             resetStart,
    output logic             timerStart,
    output logic [15:0]      delayCycles,
    output logic             busy
);

    logic [3:0] repeatsLeft;
    logic       pulseBegin;
    logic       finalStep;
    logic [1:0] doneDelay;
    logic       busyReg;

    // the reset engine takes start whenever it reports ready.
    assign pulseBegin = resetStart & resetReady;

    // a reset ends on a last step that is not chained.
    assign finalStep = timerBusy ? timerLastStep : (resetLastStep & ~resetStart);

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            resetStart  <= 1'b0;
            timerStart  <= 1'b0;
            delayCycles <= 16'd0;
            repeatsLeft <= 4'd0;
            doneDelay   <= 2'b00;
            busyReg     <= 1'b0;
        end else begin
            timerStart <= 1'b0;
            if (commandValid) begin
                busyReg     <= 1'b1;
                delayCycles <= commandWord.timerView.delayCycles;
                case (commandWord.resetView.opcode)
                    opcodePhyReset: begin
                        resetStart  <= 1'b1;
                        repeatsLeft <= commandWord.resetView.repeatCount;
                    end
                    opcodeTimedHold: begin
                        timerStart <= 1'b1;
                    end
                    default: begin
                        busyReg <= 1'b0;
                    end
                endcase
            end else if (pulseBegin) begin
                repeatsLeft <= repeatsLeft - 4'd1;
                if (repeatsLeft == 4'd1) begin
                    resetStart <= 1'b0;
                end
            end
            // two stages cover the engine level and the driver register.
            doneDelay <= {doneDelay[0], finalStep};
            if (doneDelay[1]) begin
                busyReg <= 1'b0;
            end
        end
    end

    assign busy = busyReg | commandValid;

endmodule

/* src/npmPhyResetPrimitive.sv */
`timescale 1ns/100ps

module npmPhyResetPrimitive
    import npmPrimitivePkg::*;
#(
    parameter int resetPulseCycles = defaultResetPulseCycles
) (
    input  logic iSystemClock,
    input  logic iReset,
    input  logic start,
    output logic ready,
    output logic lastStep,
    output logic engineResetLevel
);

    localparam int timerWidth = ($clog2(resetPulseCycles) > 0) ? $clog2(resetPulseCycles) : 1;

    // one-hot encoding.
    localparam logic [3:0] stateReset = 4'b0001;
    localparam logic [3:0] stateReady = 4'b0010;
    localparam logic [3:0] stateFirst = 4'b0100;
    localparam logic [3:0] stateLoop  = 4'b1000;

    logic [3:0]            stateCurrent;
    logic [3:0]            stateNext;
    logic                  readyReg;
    logic [timerWidth-1:0] timer;
    logic                  jobDone;
    logic                  levelReg;

    assign jobDone = (stateCurrent == stateLoop) &&
                     (timer == timerWidth'(resetPulseCycles - 1));

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            stateCurrent <= stateReset;
        end else begin
            stateCurrent <= stateNext;
        end
    end

    // a start seen on the last step chains straight into the next pulse.
    always_comb begin
        case (stateCurrent)
            stateReset: stateNext = stateReady;
            stateReady: stateNext = start ? stateFirst : stateReady;
            stateFirst: stateNext = stateLoop;
            stateLoop:  stateNext = jobDone ? (start ? stateFirst : stateReady) : stateLoop;
            default:    stateNext = stateReady;
        endcase
    end

    // outputs follow the state being entered.
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            readyReg <= 1'b0;
            timer    <= '0;
            levelReg <= 1'b0;
        end else begin
            readyReg <= (stateNext == stateReady);
            levelReg <= (stateNext == stateFirst) || (stateNext == stateLoop);
            if (stateNext == stateLoop) begin
                timer <= timer + 1'b1;
            end else begin
                timer <= '0;
            end
        end
    end

    assign ready            = readyReg | jobDone;
    assign lastStep         = jobDone;
    assign engineResetLevel = levelReg;

endmodule

/* src/npmTimerPrimitive.sv */
`timescale 1ns/100ps

module npmTimerPrimitive (
    input  logic        iSystemClock,
    input  logic        iReset,
    input  logic        start,
    input  logic [15:0] delayCycles,
    output logic        busy,
    output logic        lastStep,
    output logic        engineHoldLevel
);

    logic [15:0] count;
    logic        holdReg;

    // the level stays high for count values delayCycles-1 down to 0.
    assign lastStep = holdReg & (count == 16'd0);

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            holdReg <= 1'b0;
            count   <= 16'd0;
        end else begin
            if (start) begin
                holdReg <= 1'b1;
                count   <= delayCycles - 16'd1;
            end else if (lastStep) begin
                holdReg <= 1'b0;
            end else if (holdReg) begin
                count <= count - 16'd1;
            end
        end
    end

    assign busy            = holdReg;
    assign engineHoldLevel = holdReg;

endmodule

/* src/npmPhyDriver.sv */
`timescale 1ns/100ps

module npmPhyDriver (
    input  logic iSystemClock,
    input  logic iReset,
    input  logic engineResetLevel,
    input  logic engineHoldLevel,
    output logic phyReset,
    output logic phyHold,
    output logic primitiveDone,
    output logic resetEdge
);

    logic resetFalling;
    logic holdFalling;
    logic resetRising;

    // compare the engine level with the pin it is about to replace.
    assign resetRising  = engineResetLevel & ~phyReset;
    assign resetFalling = ~engineResetLevel & phyReset;
    assign holdFalling  = ~engineHoldLevel & phyHold;

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            phyReset      <= 1'b0;
            phyHold       <= 1'b0;
            primitiveDone <= 1'b0;
            resetEdge     <= 1'b0;
        end else begin
            phyReset      <= engineResetLevel;
            phyHold       <= engineHoldLevel;
            // both pulses line up with the pin change.
            primitiveDone <= resetFalling | holdFalling;
            resetEdge     <= resetRising;
        end
    end

endmodule

/* src/npmPrimitiveManager.sv */
`timescale 1ns/100ps

module npmPrimitiveManager
    import npmPrimitivePkg::*;
#(
    parameter int resetPulseCycles = defaultResetPulseCycles
) (
    input  logic        iSystemClock,
    input  logic        iReset,
    input  logic        pSel,
    input  logic        pEnable,
    input  logic        pWrite,
    input  logic [3:0]  pAddr,
    input  logic [31:0] pWData,
    output logic [31:0] pRData,
    output logic        pReady,
    output logic        pSlvErr,
    output logic        phyReset,
    output logic        phyHold
);

    primitiveCommandT commandWord;
    logic             commandValid;
    logic             busy;
    logic             primitiveDone;
    logic             resetEdge;
    logic             resetStart;
    logic             resetReady;
    logic             resetLastStep;
    logic             timerStart;
    logic [15:0]      delayCycles;
    logic             timerBusy;
    logic             timerLastStep;
    logic             engineResetLevel;
    logic             engineHoldLevel;

    npmApbRegisters npmApbRegisters_i (
        .iSystemClock(iSystemClock), .iReset(iReset), .pSel(pSel), .pEnable(pEnable),
        .pWrite(pWrite), .pAddr(pAddr), .pWData(pWData), .pRData(pRData), .pReady(pReady),
        .pSlvErr(pSlvErr), .busy(busy), .primitiveDone(primitiveDone),
        .resetEdge(resetEdge), .commandValid(commandValid), .commandWord(commandWord)
    );

    npmPrimitiveDispatcher npmPrimitiveDispatcher_i (
        .iSystemClock(iSystemClock), .iReset(iReset), .commandValid(commandValid),
        .commandWord(commandWord), .resetReady(resetReady), .resetLastStep(resetLastStep),
        .timerBusy(timerBusy), .timerLastStep(timerLastStep), .resetStart(resetStart),
        .timerStart(timerStart), .delayCycles(delayCycles), .busy(busy)
    );

    npmPhyResetPrimitive #(.resetPulseCycles(resetPulseCycles)) npmPhyResetPrimitive_i (
        .iSystemClock(iSystemClock), .iReset(iReset), .start(resetStart),
        .ready(resetReady), .lastStep(resetLastStep), .engineResetLevel(engineResetLevel)
    );

    npmTimerPrimitive npmTimerPrimitive_i (
        .iSystemClock(iSystemClock), .iReset(iReset), .start(timerStart),
        .delayCycles(delayCycles), .busy(timerBusy), .lastStep(timerLastStep),
        .engineHoldLevel(engineHoldLevel)
    );

    npmPhyDriver npmPhyDriver_i (
        .iSystemClock(iSystemClock), .iReset(iReset), .engineResetLevel(engineResetLevel),
        .engineHoldLevel(engineHoldLevel), .phyReset(phyReset), .phyHold(phyHold),
        .primitiveDone(primitiveDone), .resetEdge(resetEdge)
    );

endmodule

/* verification/npmPrimitiveManager_sva.sv */
`timescale 1ns/100ps

module npmPhyDriverChecks (
    input logic iSystemClock,
    input logic iReset,
    input logic phyReset,
    input logic phyHold,
    input logic primitiveDone,
    input logic resetEdge
);

    // only one primitive drives the phy at a time.
    pinsExclusive: assert property (@(posedge iSystemClock) disable iff (iReset)
        !(phyReset && phyHold))
        else $error("phyReset and phyHold are high in the same cycle");

    donePulse: assert property (@(posedge iSystemClock) disable iff (iReset)
        primitiveDone |=> !primitiveDone)
        else $error("primitiveDone stayed high for more than one cycle");

    // the edge pulse and the pin are registered on the same clock.
    edgeOnRise: assert property (@(posedge iSystemClock) disable iff (iReset)
        resetEdge |-> $rose(phyReset))
        else $error("resetEdge seen without a rising phyReset");

endmodule

bind npmPhyDriver npmPhyDriverChecks npmPhyDriverChecks_i (
    .iSystemClock(iSystemClock), .iReset(iReset), .phyReset(phyReset), .phyHold(phyHold),
    .primitiveDone(primitiveDone), .resetEdge(resetEdge)
);

/* verification/npmPrimitiveManagerTb.sv */
`timescale 1ns/100ps

module npmPrimitiveManagerTb
    import npmPrimitivePkg::*;
();

    localparam int resetPulseCycles = 10;
    localparam int readyTimeout     = 16;
    localparam int idleTimeout      = 400;

    logic        iSystemClock;
    logic        iReset;
    logic        pSel;
    logic        pEnable;
    logic        pWrite;
    logic [3:0]  pAddr;
    logic [31:0] pWData;
    logic [31:0] pRData;
    logic        pReady;
    logic        pSlvErr;
    logic        phyReset;
    logic        phyHold;

    integer      seed;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          testFailCount;
    int          testErrorStart;
    bit          timedOut;
    logic [31:0] lastRData;
    logic        lastSlvErr;
    logic [31:0] expResetCount;
    logic [31:0] expDoneCount;
    logic [31:0] expCommand;
    int          resetRuns[$];
    int          holdRuns[$];
    int          resetRunLength;
    int          holdRunLength;

    npmPrimitiveManager #(.resetPulseCycles(resetPulseCycles)) npmPrimitiveManager_i (
        .iSystemClock(iSystemClock), .iReset(iReset), .pSel(pSel), .pEnable(pEnable),
        .pWrite(pWrite), .pAddr(pAddr), .pWData(pWData), .pRData(pRData), .pReady(pReady),
        .pSlvErr(pSlvErr), .phyReset(phyReset), .phyHold(phyHold)
    );

    always #10 iSystemClock = ~iSystemClock;

    // measures every high run of the two pins, sampled mid-cycle.
    always @(negedge iSystemClock) begin
        if (iReset) begin
            resetRunLength = 0;
            holdRunLength  = 0;
        end else begin
            if (phyReset) begin
                resetRunLength = resetRunLength + 1;
            end else if (resetRunLength != 0) begin
                resetRuns.push_back(resetRunLength);
                resetRunLength = 0;
            end
            if (phyHold) begin
                holdRunLength = holdRunLength + 1;
            end else if (holdRunLength != 0) begin
                holdRuns.push_back(holdRunLength);
                holdRunLength = 0;
            end
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    // setup phase, then access phase until pReady; results sampled mid-cycle.
    task automatic apbTransfer(input logic write, input logic [3:0] addr,
                               input logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge iSystemClock);
        pSel    <= 1'b1;
        pEnable <= 1'b0;
        pWrite  <= write;
        pAddr   <= addr;
        pWData  <= data;
        @(posedge iSystemClock);
        pEnable <= 1'b1;
        @(negedge iSystemClock);
        // zero wait states on every access.
        checkValue("pReady", {31'd0, pReady}, 32'd1);
        while (!pReady && waited < readyTimeout) begin
            waited++;
            @(negedge iSystemClock);
        end
        if (!pReady) begin
            $display("timeout: pReady stayed low during an access to offset 0x%h", addr);
            errorCount++;
            timedOut = 1'b1;
        end
        lastRData  = pRData;
        lastSlvErr = pSlvErr;
        @(posedge iSystemClock);
        pSel    <= 1'b0;
        pEnable <= 1'b0;
        pWrite  <= 1'b0;
    endtask

    task automatic writeRegister(input logic [3:0] addr, input logic [31:0] data,
                                 input logic expectError);
        apbTransfer(1'b1, addr, data);
        checkValue("pSlvErr", {31'd0, lastSlvErr}, {31'd0, expectError});
    endtask

    task automatic readRegister(input logic [3:0] addr, input string name,
                                input logic [31:0] expected);
        apbTransfer(1'b0, addr, 32'd0);
        checkValue("pSlvErr", {31'd0, lastSlvErr}, 32'd0);
        checkValue(name, lastRData, expected);
    endtask

    task automatic waitIdle();
        int polls;
        polls = 0;
        apbTransfer(1'b0, addrStatus, 32'd0);
        while (lastRData[0] && polls < idleTimeout) begin
            polls++;
            apbTransfer(1'b0, addrStatus, 32'd0);
        end
        if (lastRData[0]) begin
            $display("timeout: busy did not clear after %0d status polls", polls);
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    // a length of 0 means that pin must not have pulsed.
    task automatic checkRuns(input int resetLength, input int holdLength);
        checkValue("phyReset runs", resetRuns.size(), (resetLength != 0) ? 1 : 0);
        checkValue("phyHold runs", holdRuns.size(), (holdLength != 0) ? 1 : 0);
        if (resetLength != 0 && resetRuns.size() == 1) begin
            checkValue("phyReset width", resetRuns[0], resetLength);
        end
        if (holdLength != 0 && holdRuns.size() == 1) begin
            checkValue("phyHold width", holdRuns[0], holdLength);
        end
    endtask

    task automatic checkRegisters(input logic [31:0] status);
        readRegister(addrStatus, "status", status);
        readRegister(addrResetCount, "resetCount", expResetCount);
        readRegister(addrDoneCount, "doneCount", expDoneCount);
        readRegister(addrCommand, "command", expCommand);
    endtask

    task automatic finishPrimitive(input int resetLength, input int holdLength);
        waitIdle();
        expDoneCount++;
        if (resetLength != 0) begin
            expResetCount++;
        end
        checkRuns(resetLength, holdLength);
        checkRegisters(32'h2);
        // clearing done must leave busy low.
        writeRegister(addrStatus, 32'h2, 1'b0);
        readRegister(addrStatus, "status", 32'h0);
    endtask

    task automatic startPrimitive(input logic [31:0] word);
        resetRuns.delete();
        holdRuns.delete();
        writeRegister(addrCommand, word, 1'b0);
        expCommand = word;
    endtask

    function automatic logic [31:0] randomResetWord(input logic [31:0] noise,
                                                    input logic [3:0] repeats);
        return {opcodePhyReset, noise[23:0], repeats};
    endfunction

    task automatic beginTest();
        testErrorStart = errorCount;
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (errorCount != testErrorStart) begin
            testFailCount++;
            $display("test %s: failed with %0d errors", name, errorCount - testErrorStart);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic runAfterReset();
        beginTest();
        checkRegisters(32'h0);
        @(negedge iSystemClock);
        checkValue("phyReset", {31'd0, phyReset}, 32'd0);
        checkValue("phyHold", {31'd0, phyHold}, 32'd0);
        endTest("after reset");
    endtask

    task automatic runResetCommands();
        logic [31:0] noise;
        logic [3:0]  repeats;
        beginTest();
        for (int i = 0; i < 6 && !timedOut; i++) begin
            noise   = $random(seed);
            repeats = 4'(1 + ({$random(seed)} % 15));
            startPrimitive(randomResetWord(noise, repeats));
            finishPrimitive(int'(repeats) * resetPulseCycles, 0);
        end
        endTest("phy reset commands");
    endtask

    task automatic runHoldCommands();
        logic [31:0] noise;
        logic [15:0] delay;
        beginTest();
        for (int i = 0; i < 6 && !timedOut; i++) begin
            noise = $random(seed);
            delay = 16'(1 + ({$random(seed)} % 300));
            startPrimitive({opcodeTimedHold, noise[11:0], delay});
            finishPrimitive(0, int'(delay));
        end
        endTest("timed hold commands");
    endtask

    task automatic runRejects();
        logic [31:0] noise;
        logic [3:0]  repeats;
        logic [3:0]  opcode;
        logic [3:0]  addr;
        int          pick;
        beginTest();
        // a second command while the first one runs is refused.
        noise   = $random(seed);
        repeats = 4'(1 + ({$random(seed)} % 15));
        startPrimitive(randomResetWord(noise, repeats));
        writeRegister(addrCommand, {opcodeTimedHold, 12'd0, 16'd40}, 1'b1);
        finishPrimitive(int'(repeats) * resetPulseCycles, 0);
        resetRuns.delete();
        holdRuns.delete();
        for (int i = 0; i < 4; i++) begin
            noise = $random(seed);
            pick  = {$random(seed)} % 14;
            opcode = (pick == 0) ? 4'd0 : 4'(pick + 2);
            writeRegister(addrCommand, {opcode, noise[27:0]}, 1'b1);
            writeRegister(addrCommand, {opcodePhyReset, noise[23:0], 4'd0}, 1'b1);
            writeRegister(addrCommand, {opcodeTimedHold, noise[11:0], 16'd0}, 1'b1);
            addr = 4'($random(seed));
            if (addr[1:0] == 2'b00) begin
                addr[1:0] = 2'b10;
            end
            writeRegister(addr, noise, 1'b1);
            apbTransfer(1'b0, addr, 32'd0);
            checkValue("pSlvErr", {31'd0, lastSlvErr}, 32'd1);
        end
        repeat (30) @(negedge iSystemClock);
        checkValue("phyReset", {31'd0, phyReset}, 32'd0);
        checkValue("phyHold", {31'd0, phyHold}, 32'd0);
        checkRuns(0, 0);
        checkRegisters(32'h0);
        endTest("rejected accesses");
    endtask

    initial begin
        seed           = 32'h5226_0673;
        errorCount     = 0;
        checkCount     = 0;
        testCount      = 0;
        testFailCount  = 0;
        timedOut       = 1'b0;
        expResetCount  = 32'd0;
        expDoneCount   = 32'd0;
        expCommand     = 32'd0;
        iSystemClock   = 1'b0;
        iReset         = 1'b1;
        pSel           = 1'b0;
        pEnable        = 1'b0;
        pWrite         = 1'b0;
        pAddr          = 4'h0;
        pWData         = 32'd0;
        repeat (5) @(posedge iSystemClock);
        iReset <= 1'b0;
        runAfterReset();
        if (!timedOut) begin
            runResetCommands();
        end
        if (!timedOut) begin
            runHoldCommands();
        end
        if (!timedOut) begin
            runRejects();
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testCount, testFailCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* npmPrimitiveManager.f */
src/npmPrimitivePkg.sv
src/npmApbRegisters.sv
src/npmPrimitiveDispatcher.sv
src/npmPhyResetPrimitive.sv
src/npmTimerPrimitive.sv
src/npmPhyDriver.sv
src/npmPrimitiveManager.sv
verification/npmPrimitiveManager_sva.sv
verification/npmPrimitiveManagerTb.sv

/* Makefile */
# Verilator build and run for the NAND PHY primitive manager.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= npmPrimitiveManagerTb
FILELIST  ?= npmPrimitiveManager.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/simulation.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, and check the log"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
